//--- source/cmprs_pkg.sv
//********************************************************************
// shared sizes, timing constants, line/frame number types and the
// state enums of the compressor frame synchronizer
//********************************************************************
`default_nettype none

package cmprs_pkg;

    localparam int FRAME_HEIGHT_BITS  = 8;    // width of a line number
    localparam int LAST_FRAME_BITS    = 4;    // frame number wraps at this width
    localparam int CMPRS_TIMEOUT_BITS = 12;

    typedef logic [FRAME_HEIGHT_BITS-1:0] line_t;
    typedef logic [LAST_FRAME_BITS-1:0]   frame_num_t;

    localparam line_t FRAME_LINES     = line_t'(16); // lines in one frame
    localparam line_t VSYNC_LATE_LINE = line_t'(2);  // source line that fires the late vsync

    localparam int LINE_CYCLES  = 4;                     // reader pace, mclk cycles per line
    localparam int PACE_BITS    = $clog2(LINE_CYCLES);
    localparam int FLUSH_CYCLES = 8;                     // stuffer drain length
    localparam int FLUSH_BITS   = $clog2(FLUSH_CYCLES);

    localparam logic [CMPRS_TIMEOUT_BITS-1:0] CMPRS_TIMEOUT = 1000; // mclk cycles

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_flush
    } stuffer_state_t;

    typedef enum logic {
        rd_idle,
        rd_read
    } reader_state_t;

endpackage

`default_nettype wire

//--- source/frame_pos_if.sv
//********************************************************************
// position of one memory channel: unfinished line, frame number and
// the frame done / frame mark strobes
//********************************************************************
`default_nettype none

interface frame_pos_if;
    import cmprs_pkg::*;

    line_t      line_unfinished; // line currently being transferred
    frame_num_t frame_number;
    logic       frame_done;      // single cycle, whole frame transferred
    logic       frame_mark;      // late vsync on the source, frame started on the destination

    modport producer (output line_unfinished, frame_number, frame_done, frame_mark);
    modport consumer (input  line_unfinished, frame_number, frame_done, frame_mark);

endinterface

`default_nettype wire

//--- source/src_frame_tracker.sv
//********************************************************************
// sensor channel position: counts written lines, fires the late
// vsync and reports frame completion with a wrapping frame number
//********************************************************************
`default_nettype none

module src_frame_tracker (
    input  logic          mclk,
    input  logic          mrst,
    input  logic          sensor_vsync, // start of a new sensor frame
    input  logic          sensor_line,  // one line written to memory
    frame_pos_if.producer pos
);
    import cmprs_pkg::*;

    logic frame_open;   // frame started and not all of its lines written yet
    logic line_stepped; // line_unfinished advanced on the last edge

    always_ff @(posedge mclk) begin
        if (mrst) begin
            pos.line_unfinished <= '0;
            pos.frame_number    <= '0;
            frame_open          <= 1'b0;
            line_stepped        <= 1'b0;
        end else begin
            line_stepped <= 1'b0;
            if (sensor_vsync) begin
                pos.line_unfinished <= '0;
                frame_open          <= 1'b1;
                // a frame cut short by a new vsync still used up its buffer
                if (frame_open) begin
                    pos.frame_number <= pos.frame_number + 1'b1;
                end
            end else if (sensor_line && frame_open) begin
                pos.line_unfinished <= pos.line_unfinished + 1'b1;
                line_stepped        <= 1'b1;
                if (pos.line_unfinished == FRAME_LINES - 1'b1) begin
                    frame_open <= 1'b0; // last line, ignore extra line strobes
                end
            end
            if (line_stepped && pos.line_unfinished == FRAME_LINES) begin
                pos.frame_number <= pos.frame_number + 1'b1; // together with frame_done
            end
        end
    end

    // strobes follow the line count by one cycle, only on the step itself
    always_ff @(posedge mclk) begin
        if (mrst) begin
            pos.frame_mark <= 1'b0;
            pos.frame_done <= 1'b0;
        end else begin
            pos.frame_mark <= line_stepped && (pos.line_unfinished == VSYNC_LATE_LINE);
            pos.frame_done <= line_stepped && (pos.line_unfinished == FRAME_LINES);
        end
    end

endmodule

`default_nettype wire

//--- source/dst_frame_reader.sv
//********************************************************************
// compressor channel reader: reads a frame line by line at a fixed
// pace, stalls while suspended and reports its position
//********************************************************************
`default_nettype none

module dst_frame_reader (
    input  logic          mclk,
    input  logic          mrst,
    input  logic          frame_start_dst, // start (or restart) reading a frame
    input  logic          suspend,         // source has not written far enough yet
    frame_pos_if.producer pos
);
    import cmprs_pkg::*;

    reader_state_t        state;
    logic [PACE_BITS-1:0] pace_cnt; // cycles spent on the current line

    always_ff @(posedge mclk) begin
        if (mrst) begin
            state               <= rd_idle;
            pace_cnt            <= '0;
            pos.line_unfinished <= '0;
            pos.frame_number    <= '0;
            pos.frame_mark      <= 1'b0;
            pos.frame_done      <= 1'b0;
        end else begin
            pos.frame_mark <= frame_start_dst; // frame started, one cycle after the request
            pos.frame_done <= 1'b0;
            if (frame_start_dst) begin
                // a start while busy simply drops the frame in progress
                state               <= rd_read;
                pace_cnt            <= '0;
                pos.line_unfinished <= '0;
            end else if (state == rd_read && !suspend) begin
                if (pace_cnt == PACE_BITS'(LINE_CYCLES - 1)) begin
                    pace_cnt            <= '0;
                    pos.line_unfinished <= pos.line_unfinished + 1'b1;
                    if (pos.line_unfinished == FRAME_LINES - 1'b1) begin
                        pos.frame_done   <= 1'b1;
                        pos.frame_number <= pos.frame_number + 1'b1;
                        state            <= rd_idle;
                    end
                end else begin
                    pace_cnt <= pace_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/stuffer_ctrl.sv
//********************************************************************
// bit stuffer model: runs during a compressed frame, then drains for
// a fixed flush time, either at frame end or when forced
//********************************************************************
`default_nettype none

module stuffer_ctrl (
    input  logic          mclk,
    input  logic          mrst,
    frame_pos_if.consumer dst,
    input  logic          force_flush_long, // abort request, may be held for many cycles
    output logic          stuffer_running
);
    import cmprs_pkg::*;

    stuffer_state_t        state;
    logic [FLUSH_BITS-1:0] flush_cnt;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            state     <= st_idle;
            flush_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (dst.frame_mark) state <= st_run; // first macroblock of a frame
                end
                st_run: begin
                    if (dst.frame_done || force_flush_long) begin
                        state     <= st_flush;
                        flush_cnt <= '0;
                    end
                end
                st_flush: begin
                    // the drain always completes, a held force flush does not extend it
                    if (flush_cnt == FLUSH_BITS'(FLUSH_CYCLES - 1)) state <= st_idle;
                    flush_cnt <= flush_cnt + 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign stuffer_running = (state != st_idle); // high while running and while flushing

endmodule

`default_nettype wire

//--- source/cmprs_frame_sync.sv
//********************************************************************
// frame synchronizer between the sensor and compressor channels:
// frame start, reader suspend, broken/aborted frame flush and the
// graceful extension of compressor enable
//********************************************************************
`default_nettype none

module cmprs_frame_sync (
    input  logic          mclk,
    input  logic          mrst,
    input  logic          cmprs_en,         // low stops compression, with graceful shutdown
    input  logic          cmprs_run,        // bonded mode, destination follows the late vsync
    input  logic          cmprs_standalone, // single cycle, one frame from memory with cmprs_run low
    input  logic          single_frame_buf, // both channels share one buffer, frame numbers stay 0
    frame_pos_if.consumer src,
    frame_pos_if.consumer dst,
    input  logic          stuffer_running,
    output logic          frame_start_dst,
    output logic          suspend,
    output logic          force_flush_long,
    output logic          cmprs_en_extend,  // keeps the compressor alive until the stuffer drains
    output logic          reading_frame
);
    import cmprs_pkg::*;

    logic                          bonded_mode;
    logic                          frames_differ;         // single buffer, source already moved on
    logic                          frame_numbers_differ;  // multi buffer, channels on different frames
    logic                          line_numbers_sync;     // source line is ahead of the reader
    logic                          broken_frame;
    logic                          aborted_frame;
    logic                          stuffer_running_d;
    logic                          cmprs_en_d;
    logic [CMPRS_TIMEOUT_BITS-1:0] timeout;
    logic                          extend_stop;

    // shutdown ends when the stuffer is seen idle or the timeout expires
    assign extend_stop = !cmprs_en && ((timeout == '0) || !stuffer_running_d);

    always_ff @(posedge mclk) begin
        if (mrst) begin
            cmprs_en_extend <= 1'b0;
            timeout         <= '0;
        end else begin
            if (cmprs_en)         cmprs_en_extend <= 1'b1;
            else if (extend_stop) cmprs_en_extend <= 1'b0;

            if (cmprs_en)              timeout <= CMPRS_TIMEOUT;
            else if (!cmprs_en_extend) timeout <= '0;
            else if (timeout != '0)    timeout <= timeout - 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            stuffer_running_d <= 1'b0;
            cmprs_en_d        <= 1'b0;
            broken_frame      <= 1'b0;
            aborted_frame     <= 1'b0;
            force_flush_long  <= 1'b0;
        end else begin
            stuffer_running_d <= stuffer_running;
            cmprs_en_d        <= cmprs_en;
            // new source frame while the old one is still read from memory
            broken_frame  <= cmprs_en && cmprs_run && src.frame_mark && reading_frame;
            aborted_frame <= cmprs_en_d && !cmprs_en && stuffer_running_d; // disabled mid-frame
            // the request is held until the stuffer has drained or shutdown ends
            if (!stuffer_running_d || !cmprs_en_extend || extend_stop) begin
                force_flush_long <= 1'b0;
            end else if (broken_frame || aborted_frame) begin
                force_flush_long <= 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            reading_frame   <= 1'b0;
            frame_start_dst <= 1'b0;
            bonded_mode     <= 1'b0;
            frames_differ   <= 1'b0;
        end else begin
            if (!cmprs_en || dst.frame_done || (cmprs_run && src.frame_mark)) begin
                reading_frame <= 1'b0;
            end else if (dst.frame_mark) begin
                reading_frame <= 1'b1;
            end

            // bonded starts wait for the previous frame to be read out
            frame_start_dst <= cmprs_en && (cmprs_run ? (src.frame_mark && !reading_frame)
                                                      : cmprs_standalone);

            if (!cmprs_en)             bonded_mode <= 1'b0;
            else if (cmprs_run)        bonded_mode <= 1'b1;
            else if (cmprs_standalone) bonded_mode <= 1'b0;

            if (!cmprs_en || !cmprs_run || src.frame_mark) frames_differ <= 1'b0;
            else if (src.frame_done)                       frames_differ <= 1'b1;
        end
    end

    // comparison stage, then the suspend decision one cycle later
    always_ff @(posedge mclk) begin
        if (mrst) begin
            frame_numbers_differ <= 1'b0;
            line_numbers_sync    <= 1'b0;
            suspend              <= 1'b0;
        end else begin
            frame_numbers_differ <= (src.frame_number != dst.frame_number);
            line_numbers_sync    <= (src.line_unfinished > dst.line_unfinished);
            suspend <= bonded_mode &&
                       !((single_frame_buf ? frames_differ : frame_numbers_differ) ||
                         line_numbers_sync);
        end
    end

endmodule

`default_nettype wire

//--- source/cmprs_frame_sync_top.sv
//********************************************************************
// top level: sensor tracker, compressor reader, stuffer model and
// the frame synchronizer joined by two channel position interfaces
//********************************************************************
`default_nettype none

module cmprs_frame_sync_top (
    input  logic                   mclk,
    input  logic                   mrst,
    input  logic                   cmprs_en,
    input  logic                   cmprs_run,
    input  logic                   cmprs_standalone,
    input  logic                   single_frame_buf,
    input  logic                   sensor_vsync,
    input  logic                   sensor_line,
    output logic                   frame_start_dst,
    output logic                   suspend,
    output logic                   force_flush_long,
    output logic                   cmprs_en_extend,
    output logic                   reading_frame,
    output logic                   stuffer_running,
    output logic                   dst_frame_done,
    output cmprs_pkg::line_t       dst_line,
    output cmprs_pkg::frame_num_t  dst_frame_number
);

    frame_pos_if src_pos ();
    frame_pos_if dst_pos ();

    src_frame_tracker src_frame_tracker_i (
        .mclk         (mclk),
        .mrst         (mrst),
        .sensor_vsync (sensor_vsync),
        .sensor_line  (sensor_line),
        .pos          (src_pos.producer)
    );

    dst_frame_reader dst_frame_reader_i (
        .mclk            (mclk),
        .mrst            (mrst),
        .frame_start_dst (frame_start_dst),
        .suspend         (suspend),
        .pos             (dst_pos.producer)
    );

    stuffer_ctrl stuffer_ctrl_i (
        .mclk             (mclk),
        .mrst             (mrst),
        .dst              (dst_pos.consumer),
        .force_flush_long (force_flush_long),
        .stuffer_running  (stuffer_running)
    );

    cmprs_frame_sync cmprs_frame_sync_i (
        .mclk             (mclk),
        .mrst             (mrst),
        .cmprs_en         (cmprs_en),
        .cmprs_run        (cmprs_run),
        .cmprs_standalone (cmprs_standalone),
        .single_frame_buf (single_frame_buf),
        .src              (src_pos.consumer),
        .dst              (dst_pos.consumer),
        .stuffer_running  (stuffer_running),
        .frame_start_dst  (frame_start_dst),
        .suspend          (suspend),
        .force_flush_long (force_flush_long),
        .cmprs_en_extend  (cmprs_en_extend),
        .reading_frame    (reading_frame)
    );

    // reader position brought out for observation
    assign dst_frame_done   = dst_pos.frame_done;
    assign dst_line         = dst_pos.line_unfinished;
    assign dst_frame_number = dst_pos.frame_number;

endmodule

`default_nettype wire

//--- testbench/cmprs_frame_sync_chk.sv
//**********************************************************************
// concurrent assertions on the frame synchronizer outputs, bound
// into cmprs_frame_sync
//**********************************************************************
`default_nettype none

module cmprs_frame_sync_chk (
    input logic mclk,
    input logic mrst,
    input logic cmprs_en,
    input logic cmprs_run,
    input logic cmprs_standalone,
    input logic frame_start_dst,
    input logic suspend,
    input logic force_flush_long,
    input logic cmprs_en_extend
);
    timeunit 1ns;
    timeprecision 1ps;

    // a forced flush only makes sense while the compressor is still alive
    flush_in_extend: assert property (@(posedge mclk) disable iff (mrst)
        force_flush_long |-> cmprs_en_extend)
        else $error("force_flush_long high while cmprs_en_extend is low");

    start_is_pulse: assert property (@(posedge mclk) disable iff (mrst)
        frame_start_dst |=> !frame_start_dst)
        else $error("frame_start_dst held longer than one cycle");

    // bonded mode ends on disable or on a standalone strobe and suspend sees that two cycles later
    suspend_bonded: assert property (@(posedge mclk) disable iff (mrst)
        suspend |-> $past(cmprs_en && (cmprs_run || !cmprs_standalone), 2))
        else $error("suspend high while bonded mode was off");

endmodule

bind cmprs_frame_sync cmprs_frame_sync_chk chk_i (
    .mclk             (mclk),
    .mrst             (mrst),
    .cmprs_en         (cmprs_en),
    .cmprs_run        (cmprs_run),
    .cmprs_standalone (cmprs_standalone),
    .frame_start_dst  (frame_start_dst),
    .suspend          (suspend),
    .force_flush_long (force_flush_long),
    .cmprs_en_extend  (cmprs_en_extend)
);

`default_nettype wire

//--- testbench/cmprs_frame_sync_tb.sv
//**********************************************************************
// testbench for the frame synchronizer top with clock, reset, LFSR
// line gaps, one compare task and the directed tests
//**********************************************************************
`default_nettype none

module cmprs_frame_sync_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cmprs_pkg::*;

    logic mclk, mrst, cmprs_en, cmprs_run, cmprs_standalone, single_frame_buf;
    logic sensor_vsync, sensor_line;
    logic frame_start_dst, suspend, force_flush_long, cmprs_en_extend;
    logic reading_frame, stuffer_running, dst_frame_done;
    line_t      dst_line;
    frame_num_t dst_frame_number;
    logic [31:0] lfsr;

    cmprs_frame_sync_top i_cmprs_frame_sync_top (.*);

    initial begin
        mclk = 1'b0;
        forever #50 mclk = ~mclk; // 100 ns period
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h",
                               $time, name, actual, expected));
        end
    endtask

    // galois lfsr stepped once per bit taken
    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    task automatic apply_reset();
        @(negedge mclk);
        mrst = 1'b1;
        {cmprs_en, cmprs_run, cmprs_standalone, single_frame_buf} = '0;
        {sensor_vsync, sensor_line} = '0;
        repeat (8) @(negedge mclk);
        mrst = 1'b0;
    endtask

    task automatic pulse_vsync();
        sensor_vsync = 1'b1;
        @(negedge mclk);
        sensor_vsync = 1'b0;
    endtask

    task automatic send_lines(input int n);
        repeat (n) begin
            sensor_line = 1'b1;
            @(negedge mclk);
            sensor_line = 1'b0;
            @(negedge mclk);
        end
    endtask

    task automatic reset_outputs_low();
        apply_reset();
        @(negedge mclk);
        check_value("frame_start_dst", 32'(frame_start_dst), 0);
        check_value("suspend", 32'(suspend), 0);
        check_value("force_flush_long", 32'(force_flush_long), 0);
        check_value("cmprs_en_extend", 32'(cmprs_en_extend), 0);
        check_value("reading_frame", 32'(reading_frame), 0);
        check_value("stuffer_running", 32'(stuffer_running), 0);
        check_value("dst_frame_done", 32'(dst_frame_done), 0);
    endtask

    task automatic standalone_frame();
        frame_num_t start_num;
        int cycles;
        apply_reset();
        cmprs_en = 1'b1;
        @(negedge mclk);
        start_num        = dst_frame_number;
        cmprs_standalone = 1'b1;   // single strobe with cmprs_run low
        @(negedge mclk);
        cmprs_standalone = 1'b0;
        check_value("frame_start_dst", 32'(frame_start_dst), 1);
        @(negedge mclk);
        check_value("frame_start_dst", 32'(frame_start_dst), 0);
        cycles = 0;
        while (!dst_frame_done) begin
            check_value("suspend", 32'(suspend), 0);
            if (cycles > int'(FRAME_LINES) * LINE_CYCLES + 20)
                fail_run("timeout waiting for dst_frame_done in standalone mode");
            @(negedge mclk);
            cycles++;
        end
        check_value("dst_line", 32'(dst_line), 32'(FRAME_LINES));
        check_value("dst_frame_number", 32'(dst_frame_number),
                    32'(frame_num_t'(start_num + 1'b1)));
    endtask

    task automatic bonded_frame();
        int issued, gap, cycles, late_cycle;
        apply_reset();
        cmprs_en  = 1'b1;
        cmprs_run = 1'b1;
        @(negedge mclk);
        pulse_vsync();
        issued     = 0;
        gap        = 0;
        cycles     = 0;
        late_cycle = -1;
        // one pass per cycle checks the outputs and then decides the next sensor line
        while (!dst_frame_done) begin
            if (frame_start_dst) begin
                // line count, late vsync and start each take one edge after the line strobe
                if (late_cycle < 0) fail_run("frame_start_dst came before the late vsync line");
                check_value("frame_start_dst cycle", 32'(cycles), 32'(late_cycle + 3));
            end
            if (issued > int'(VSYNC_LATE_LINE))
                check_value("dst_line <= source lines", 32'(int'(dst_line) <= issued), 1);
            sensor_line = 1'b0;
            if (issued < int'(FRAME_LINES)) begin
                if (gap == 0) begin
                    sensor_line = 1'b1;
                    issued++;
                    if (issued == int'(VSYNC_LATE_LINE)) late_cycle = cycles;
                    gap = random_bits(3);
                end else begin
                    gap--;
                end
            end
            if (cycles > 2000) fail_run("timeout waiting for the bonded frame to complete");
            @(negedge mclk);
            cycles++;
        end
        sensor_line = 1'b0;
        check_value("source lines at dst frame end", 32'(issued), 32'(FRAME_LINES));
        check_value("dst_frame_number", 32'(dst_frame_number), 1);
    endtask

    task automatic broken_frame_flush();
        int cycles;
        apply_reset();
        cmprs_en  = 1'b1;
        cmprs_run = 1'b1;
        @(negedge mclk);
        pulse_vsync();
        send_lines(6);
        check_value("reading_frame", 32'(reading_frame), 1);
        pulse_vsync();                     // next sensor frame while the old one is read
        send_lines(int'(VSYNC_LATE_LINE));
        cycles = 0;
        while (!force_flush_long) begin
            if (cycles > 10) fail_run("force_flush_long did not rise after the broken frame");
            @(negedge mclk);
            cycles++;
        end
        cycles = 0;
        while (stuffer_running) begin
            if (cycles > FLUSH_CYCLES + 4) fail_run("stuffer kept running after the forced flush");
            @(negedge mclk);
            cycles++;
        end
        cycles = 0;
        while (force_flush_long) begin
            if (cycles > 4) fail_run("force_flush_long stayed high after the stuffer stopped");
            @(negedge mclk);
            cycles++;
        end
    endtask

    task automatic graceful_disable();
        int cycles;
        apply_reset();
        cmprs_en = 1'b1;
        @(negedge mclk);
        cmprs_standalone = 1'b1;
        @(negedge mclk);
        cmprs_standalone = 1'b0;
        cycles = 0;
        while (dst_line < line_t'(4)) begin
            if (cycles > 40) fail_run("reader did not reach line 4 before disable");
            @(negedge mclk);
            cycles++;
        end
        cmprs_en = 1'b0;  // mid frame
        cycles   = 0;
        while (reading_frame || !force_flush_long) begin
            if (cycles > 6) fail_run("disable did not end reading_frame and force a flush");
            @(negedge mclk);
            cycles++;
        end
        cycles = 0;
        while (stuffer_running) begin
            check_value("cmprs_en_extend", 32'(cmprs_en_extend), 1);
            if (cycles > FLUSH_CYCLES + 6) fail_run("stuffer did not stop after the disable");
            @(negedge mclk);
            cycles++;
        end
        cycles = 0;
        // shutdown ends on the stopped stuffer, long before the timeout could expire
        while (cmprs_en_extend) begin
            if (cycles > 4) fail_run("cmprs_en_extend did not fall soon after the stuffer stopped");
            @(negedge mclk);
            cycles++;
        end
    endtask

    initial begin
        lfsr = 32'h2b70_0b7f;
        mrst = 1'b1;
        {cmprs_en, cmprs_run, cmprs_standalone, single_frame_buf} = '0;
        {sensor_vsync, sensor_line} = '0;
        reset_outputs_low();
        standalone_frame();
        bonded_frame();
        broken_frame_flush();
        graceful_disable();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cmprs_frame_sync_top.f
source/cmprs_pkg.sv
source/frame_pos_if.sv
source/src_frame_tracker.sv
source/dst_frame_reader.sv
source/stuffer_ctrl.sv
source/cmprs_frame_sync.sv
source/cmprs_frame_sync_top.sv
testbench/cmprs_frame_sync_chk.sv
testbench/cmprs_frame_sync_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the frame synchronizer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f cmprs_frame_sync_top.f \
    --top-module cmprs_frame_sync_tb \
    -o cmprs_frame_sync_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/cmprs_frame_sync_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
